/* hdl/mem_main_macros.svh */
`ifndef MEM_MAIN_MACROS_SVH
`define MEM_MAIN_MACROS_SVH

// Four RT cores share the memory with one MC port
`define NUM_RT 4
`define NUM_SRC (`NUM_RT + 1)

// Must stay a power of two, the bank index is taken straight from address bits
`define NUM_BANK 4

`define LINE_W 128
`define ADDR_W 32

// Word address bits in use, bank bits included
`define WORD_ADDR_W 10

`endif

/* hdl/mem_main_pkg.sv */
`default_nettype none

`include "mem_main_macros.svh"

package mem_main_pkg;

    typedef logic [`LINE_W-1:0] line_t;
    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [$clog2(`NUM_BANK)-1:0] bank_idx_t;
    typedef logic [`WORD_ADDR_W-$clog2(`NUM_BANK)-1:0] bank_row_t;
    typedef logic [$clog2(`NUM_SRC)-1:0] req_src_t; // RT ports first, MC port last
    typedef logic [`NUM_SRC-1:0] src_mask_t;

    // Byte address bits 1:0 are dropped, the next bits pick the bank
    function automatic bank_idx_t addr_to_bank(input addr_t addr);
        return addr[2 +: $bits(bank_idx_t)];
    endfunction

    function automatic bank_row_t addr_to_row(input addr_t addr);
        return addr[2 + $bits(bank_idx_t) +: $bits(bank_row_t)];
    endfunction

endpackage

`default_nettype wire

/* hdl/mem_bank_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface bank_req_if;
    import mem_main_pkg::*;

    logic      valid; // One cycle per granted access
    logic      we;
    req_src_t  src;
    bank_row_t row;
    line_t     wdata;

    modport arb (output valid, output we, output src, output row, output wdata);
    modport bank (input valid, input we, input src, input row, input wdata);
endinterface

interface bank_resp_if;
    import mem_main_pkg::*;

    logic     valid;
    logic     we;
    req_src_t src;
    line_t    rdata; // Only meaningful when we is low

    modport bank (output valid, output we, output src, output rdata);
    modport router (input valid, input we, input src, input rdata);
endinterface

`default_nettype wire

/* hdl/mem_port_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_main_macros.svh"

module mem_port_arbiter (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [`NUM_RT-1:0]    we_rt,
    input  wire logic [`NUM_RT-1:0]    re_rt,
    input  wire mem_main_pkg::addr_t   addr_rt [`NUM_RT],
    input  wire mem_main_pkg::line_t   wdata_rt [`NUM_RT],
    input  wire logic                  re_mc,
    input  wire mem_main_pkg::addr_t   addr_mc,
    input  wire mem_main_pkg::src_mask_t done,
    bank_req_if.arb                    bank_req [`NUM_BANK]
);
    import mem_main_pkg::*;

    src_mask_t req_vec;
    src_mask_t we_src;
    addr_t     addr_src [`NUM_SRC];
    line_t     wdata_src [`NUM_SRC];
    src_mask_t busy; // Set from grant until the router's rdy pulse
    src_mask_t granted;
    logic [`NUM_BANK-1:0][`NUM_SRC-1:0] grant;

    assign req_vec = {re_mc, we_rt | re_rt};
    assign we_src = {1'b0, we_rt}; // A write wins when we and re are both set

    always_comb begin
        for (int i = 0; i < `NUM_RT; i++) begin
            addr_src[i] = addr_rt[i];
            wdata_src[i] = wdata_rt[i];
        end
        addr_src[`NUM_RT] = addr_mc;
        wdata_src[`NUM_RT] = '0;
    end

    for (genvar b = 0; b < `NUM_BANK; b++) begin : g_bank
        src_mask_t cand;
        req_src_t  ptr;
        req_src_t  pick;
        logic      hit;

        always_comb begin
            int idx;
            for (int s = 0; s < `NUM_SRC; s++) begin
                cand[s] = req_vec[s] && !busy[s] &&
                          (addr_to_bank(addr_src[s]) == bank_idx_t'(b));
            end
            hit = 1'b0;
            pick = ptr;
            // Scan downward so the candidate closest to ptr is the last one kept
            for (int off = `NUM_SRC - 1; off >= 0; off--) begin
                idx = int'(ptr) + off;
                if (idx >= `NUM_SRC) idx -= `NUM_SRC;
                if (cand[idx]) begin
                    hit = 1'b1;
                    pick = req_src_t'(idx);
                end
            end
        end

        assign grant[b] = hit ? (src_mask_t'(1) << pick) : '0;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                ptr <= '0;
                bank_req[b].valid <= 1'b0;
            end else begin
                bank_req[b].valid <= hit;
                if (hit) ptr <= (pick == req_src_t'(`NUM_SRC - 1)) ? '0 : pick + 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (hit) begin
                bank_req[b].we <= we_src[pick];
                bank_req[b].src <= pick;
                bank_req[b].row <= addr_to_row(addr_src[pick]);
                bank_req[b].wdata <= wdata_src[pick];
            end
        end
    end

    always_comb begin
        granted = '0;
        for (int s = 0; s < `NUM_SRC; s++) begin
            for (int b = 0; b < `NUM_BANK; b++) begin
                granted[s] = granted[s] | grant[b][s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) busy <= '0;
        else busy <= (busy & ~done) | granted;
    end

    // Every rdy pulse must close an access that was granted here
    a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (done & ~busy) == '0);

endmodule

`default_nettype wire

/* hdl/mem_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_bank (
    input  wire logic  clk,
    input  wire logic  rst_n,
    bank_req_if.bank   req,
    bank_resp_if.bank  resp
);
    import mem_main_pkg::*;

    localparam int ROWS = 1 << $bits(bank_row_t);

    line_t mem [ROWS];

    always_ff @(posedge clk) begin
        if (req.valid) begin
            if (req.we) begin
                mem[req.row] <= req.wdata;
            end else begin
                resp.rdata <= mem[req.row]; // Write responses keep the old rdata
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) resp.valid <= 1'b0;
        else resp.valid <= req.valid;
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            resp.we <= req.we;
            resp.src <= req.src;
        end
    end

    // The arbiter clears valid on its first reset edge
    a_idle_in_reset: assert property (@(posedge clk)
        !rst_n && $past(!rst_n) |-> !req.valid);

endmodule

`default_nettype wire

/* hdl/mem_resp_router.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_main_macros.svh"

module mem_resp_router (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    bank_resp_if.router                  resp [`NUM_BANK],
    output logic [`NUM_RT-1:0]           rdy_rt,
    output mem_main_pkg::line_t          data_rt_out [`NUM_RT],
    output logic                         rdy_mc,
    output mem_main_pkg::line_t          data_mc_out,
    output mem_main_pkg::src_mask_t      done
);
    import mem_main_pkg::*;

    logic [`NUM_BANK-1:0] resp_valid;
    logic [`NUM_BANK-1:0] resp_we;
    req_src_t             resp_src [`NUM_BANK];
    line_t                resp_rdata [`NUM_BANK];
    logic [`NUM_SRC-1:0][`NUM_BANK-1:0] hit_mat;
    src_mask_t            rdy_d;
    src_mask_t            rdy_q;
    src_mask_t            rd_hit;
    line_t                rd_data [`NUM_SRC];
    line_t                data_q [`NUM_SRC];

    for (genvar b = 0; b < `NUM_BANK; b++) begin : g_gather
        assign resp_valid[b] = resp[b].valid;
        assign resp_we[b] = resp[b].we;
        assign resp_src[b] = resp[b].src;
        assign resp_rdata[b] = resp[b].rdata;
    end

    always_comb begin
        for (int s = 0; s < `NUM_SRC; s++) begin
            rd_hit[s] = 1'b0;
            rd_data[s] = '0;
            for (int b = 0; b < `NUM_BANK; b++) begin
                hit_mat[s][b] = resp_valid[b] && (resp_src[b] == req_src_t'(s));
                if (hit_mat[s][b] && !resp_we[b]) begin
                    rd_hit[s] = 1'b1;
                    rd_data[s] = resp_rdata[b];
                end
            end
            rdy_d[s] = |hit_mat[s];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) rdy_q <= '0;
        else rdy_q <= rdy_d;
    end

    // Only reads load the data register
    always_ff @(posedge clk) begin
        for (int s = 0; s < `NUM_SRC; s++) begin
            if (rd_hit[s]) data_q[s] <= rd_data[s];
        end
    end

    assign rdy_rt = rdy_q[`NUM_RT-1:0];
    assign rdy_mc = rdy_q[`NUM_RT];
    assign done = rdy_q; // Frees the busy bits in the arbiter
    assign data_mc_out = data_q[`NUM_RT];

    for (genvar i = 0; i < `NUM_RT; i++) begin : g_out
        assign data_rt_out[i] = data_q[i];
    end

    for (genvar s = 0; s < `NUM_SRC; s++) begin : g_chk
        a_single_resp: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(hit_mat[s]));
    end

endmodule

`default_nettype wire

/* hdl/mem_main.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_main_macros.svh"

module mem_main (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic [`NUM_RT-1:0]   we_rt,
    input  wire logic [`NUM_RT-1:0]   re_rt,
    input  wire mem_main_pkg::addr_t  addr_rt [`NUM_RT],
    input  wire mem_main_pkg::line_t  data_rt_in [`NUM_RT],
    output logic [`NUM_RT-1:0]        rdy_rt,
    output mem_main_pkg::line_t       data_rt_out [`NUM_RT],
    input  wire logic                 re_mc,
    input  wire mem_main_pkg::addr_t  addr_mc,
    output logic                      rdy_mc,
    output mem_main_pkg::line_t       data_mc_out
);
    import mem_main_pkg::*;

    src_mask_t done;

    bank_req_if  bank_req [`NUM_BANK] ();
    bank_resp_if bank_resp [`NUM_BANK] ();

    mem_port_arbiter i_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .we_rt    (we_rt),
        .re_rt    (re_rt),
        .addr_rt  (addr_rt),
        .wdata_rt (data_rt_in),
        .re_mc    (re_mc),
        .addr_mc  (addr_mc),
        .done     (done),
        .bank_req (bank_req)
    );

    // One storage bank per interleave slot
    for (genvar b = 0; b < `NUM_BANK; b++) begin : g_bank
        mem_bank i_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (bank_req[b]),
            .resp  (bank_resp[b])
        );
    end

    mem_resp_router i_router (
        .clk         (clk),
        .rst_n       (rst_n),
        .resp        (bank_resp),
        .rdy_rt      (rdy_rt),
        .data_rt_out (data_rt_out),
        .rdy_mc      (rdy_mc),
        .data_mc_out (data_mc_out),
        .done        (done)
    );

endmodule

`default_nettype wire

/* tb/mem_main_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_main_macros.svh"

module mem_main_tb;
    import mem_main_pkg::*;

    localparam int WAIT_LIMIT = 200;
    localparam int PAIRS = 24;
    localparam int MC_READS = 30;

    logic                clk;
    logic                rst_n;
    logic [`NUM_RT-1:0]  we_rt;
    logic [`NUM_RT-1:0]  re_rt;
    addr_t               addr_rt [`NUM_RT];
    line_t               data_rt_in [`NUM_RT];
    logic [`NUM_RT-1:0]  rdy_rt;
    line_t               data_rt_out [`NUM_RT];
    logic                re_mc;
    addr_t               addr_mc;
    logic                rdy_mc;
    line_t               data_mc_out;

    line_t   model [addr_t]; // Last completed write per address
    addr_t   written_q [$];
    logic [`NUM_RT-1:0] pend; // Request held by the port
    logic [`NUM_RT-1:0] cur_rd;
    logic [`NUM_RT-1:0] rd_seen; // Port has completed a read
    line_t   exp_rt [`NUM_RT];
    int      age_rt [`NUM_RT];
    logic [`NUM_RT-1:0] wr_act;
    addr_t   wr_addr [`NUM_RT];
    logic    mc_pend;
    line_t   exp_mc;
    int      age_mc;
    int      errors;
    int      timeouts;
    int      done_cnt;
    bit      aborted;

    mem_main i_mem_main (
        .clk         (clk),
        .rst_n       (rst_n),
        .we_rt       (we_rt),
        .re_rt       (re_rt),
        .addr_rt     (addr_rt),
        .data_rt_in  (data_rt_in),
        .rdy_rt      (rdy_rt),
        .data_rt_out (data_rt_out),
        .re_mc       (re_mc),
        .addr_mc     (addr_mc),
        .rdy_mc      (rdy_mc),
        .data_mc_out (data_mc_out)
    );

    always #4 clk = ~clk;

    // Cycles a request has been visible at a rising edge
    always @(posedge clk) begin
        for (int p = 0; p < `NUM_RT; p++) age_rt[p] <= pend[p] ? age_rt[p] + 1 : 0;
        age_mc <= mc_pend ? age_mc + 1 : 0;
    end

    for (genvar p = 0; p < `NUM_RT; p++) begin : g_chk
        a_rdy_held: assert property (@(posedge clk) disable iff (!rst_n)
            rdy_rt[p] |-> pend[p])
            else begin
                errors++;
                $display("rdy_rt[%0d] pulsed at %0t without a held request", p, $time);
            end
        a_one_pulse: assert property (@(posedge clk) disable iff (!rst_n)
            rdy_rt[p] |=> !rdy_rt[p])
            else begin
                errors++;
                $display("rdy_rt[%0d] stayed high for more than one cycle at %0t", p, $time);
            end
        a_latency: assert property (@(posedge clk) disable iff (!rst_n)
            rdy_rt[p] |-> (age_rt[p] >= 3 && age_rt[p] <= `NUM_RT + 3))
            else begin
                errors++;
                $display("rdy_rt[%0d] came after %0d cycles at %0t, outside the allowed range",
                         p, $sampled(age_rt[p]), $time);
            end
        a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
            rdy_rt[p] && cur_rd[p] |-> data_rt_out[p] === exp_rt[p])
            else begin
                errors++;
                $display("** Error at %0t: data_rt_out[%0d] expected %h got %h",
                         $time, p, exp_rt[p], $sampled(data_rt_out[p]));
            end
        a_write_keeps: assert property (@(posedge clk) disable iff (!rst_n)
            rdy_rt[p] && !cur_rd[p] && rd_seen[p] |-> data_rt_out[p] === exp_rt[p])
            else begin
                errors++;
                $display("** Error at %0t: data_rt_out[%0d] expected %h got %h",
                         $time, p, exp_rt[p], $sampled(data_rt_out[p]));
            end
    end

    a_mc_held: assert property (@(posedge clk) disable iff (!rst_n)
        rdy_mc |-> mc_pend && (age_mc >= 3 && age_mc <= `NUM_RT + 3))
        else begin
            errors++;
            $display("rdy_mc pulsed at %0t without a held request or at a bad latency", $time);
        end
    a_mc_pulse: assert property (@(posedge clk) disable iff (!rst_n) rdy_mc |=> !rdy_mc)
        else begin
            errors++;
            $display("rdy_mc stayed high for more than one cycle at %0t", $time);
        end
    a_mc_data: assert property (@(posedge clk) disable iff (!rst_n)
        rdy_mc |-> data_mc_out === exp_mc)
        else begin
            errors++;
            $display("** Error at %0t: data_mc_out expected %h got %h",
                     $time, exp_mc, $sampled(data_mc_out));
        end

    function automatic line_t rand_line();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    function automatic bit write_in_flight(input addr_t a);
        for (int p = 0; p < `NUM_RT; p++) begin
            if (wr_act[p] && wr_addr[p] == a) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Port p owns rows whose top two bits equal p
    task automatic rt_access(input int p, input bit wr, input addr_t a, input line_t d);
        int n;
        cur_rd[p] = !wr;
        exp_rt[p] = wr ? exp_rt[p] : model[a];
        we_rt[p] = wr;
        re_rt[p] = !wr;
        addr_rt[p] = a;
        data_rt_in[p] = d;
        pend[p] = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rdy_rt[p] && n < WAIT_LIMIT);
        if (!rdy_rt[p]) begin
            timeouts++;
            $display("RT port %0d got no rdy for address %h", p, a);
        end else if (wr) begin
            model[a] = d;
            written_q.push_back(a);
        end else begin
            rd_seen[p] = 1'b1;
        end
        @(posedge clk);
        #1;
        we_rt[p] = 1'b0;
        re_rt[p] = 1'b0;
        pend[p] = 1'b0;
        wr_act[p] = 1'b0;
    endtask

    task automatic rt_traffic(input int p, input bit bank0);
        addr_t a;
        int    tries;
        for (int k = 0; k < PAIRS; k++) begin
            @(posedge clk);
            #1;
            tries = 0;
            do begin
                a = {20'd0, 2'(p), 6'($urandom()), bank0 ? 2'd0 : 2'($urandom()), 2'b00};
                tries++;
            end while (mc_pend && a == addr_mc && tries < 16);
            wr_addr[p] = a;
            wr_act[p] = 1'b1;
            rt_access(p, 1'b1, a, rand_line());
            @(posedge clk);
            #1;
            rt_access(p, 1'b0, a, '0);
        end
        done_cnt++;
    endtask

    // MC inputs move 2 ns after the edge, so RT write choices are already visible
    task automatic mc_traffic(input bit bank0);
        addr_t a;
        int    n;
        bit    found;
        for (int k = 0; k < MC_READS; k++) begin
            @(posedge clk);
            #2;
            found = 1'b0;
            n = 0;
            while (!found && n < WAIT_LIMIT) begin
                if (written_q.size() > 0) begin
                    a = written_q[$urandom() % written_q.size()];
                    found = (!bank0 || a[3:2] == 2'd0) && !write_in_flight(a);
                end
                if (!found) begin
                    @(posedge clk);
                    #2;
                    n++;
                end
            end
            if (!found) begin
                timeouts++;
                $display("MC port found no completed write to read back");
                break;
            end
            exp_mc = model[a];
            addr_mc = a;
            re_mc = 1'b1;
            mc_pend = 1'b1;
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!rdy_mc && n < WAIT_LIMIT);
            if (!rdy_mc) begin
                timeouts++;
                $display("MC port got no rdy for address %h", a);
            end
            @(posedge clk);
            #2;
            re_mc = 1'b0;
            mc_pend = 1'b0;
        end
        done_cnt++;
    endtask

    task automatic run_phase(input int phase, input bit bank0);
        int n;
        done_cnt = 0;
        for (int p = 0; p < `NUM_RT; p++) begin
            automatic int q = p;
            fork
                rt_traffic(q, bank0);
            join_none
        end
        fork
            mc_traffic(bank0);
        join_none
        n = 0;
        while (done_cnt < `NUM_SRC && n < 20 * WAIT_LIMIT * PAIRS) begin
            @(posedge clk);
            n++;
        end
        if (done_cnt < `NUM_SRC) begin
            timeouts++;
            aborted = 1'b1;
            $display("Traffic phase %0d did not finish in time", phase);
        end
    endtask

    initial begin
        void'($urandom(32'h4669_1311));
        clk = 1'b0;
        rst_n = 1'b0;
        we_rt = '0;
        re_rt = '0;
        re_mc = 1'b0;
        addr_mc = '0;
        pend = '0;
        cur_rd = '0;
        rd_seen = '0;
        wr_act = '0;
        mc_pend = 1'b0;
        exp_mc = '0;
        errors = 0;
        timeouts = 0;
        aborted = 1'b0;
        for (int p = 0; p < `NUM_RT; p++) begin
            addr_rt[p] = '0;
            data_rt_in[p] = '0;
            exp_rt[p] = '0;
            wr_addr[p] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_phase(1, 1'b0); // Spread over all banks
        if (!aborted) run_phase(2, 1'b1); // Everyone hammers bank 0
        repeat (4) @(posedge clk);
        $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mem_main.f */
+incdir+hdl
hdl/mem_main_pkg.sv
hdl/mem_bank_if.sv
hdl/mem_port_arbiter.sv
hdl/mem_bank.sv
hdl/mem_resp_router.sv
hdl/mem_main.sv
tb/mem_main_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the mem_main testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f mem_main.f --top-module mem_main_tb -o mem_main_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mem_main_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    exit 1
fi
if ! grep -q "No errors" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
